//--- hdl/qspi_pkg.sv
package qspi_pkg;

    // Bus geometry
    localparam int addr_w   = 24;
    localparam int data_w   = 32;
    localparam int nibble_w = 4;    // IO0..IO3
    localparam int cmd_w    = 8;

    // Phase lengths
    localparam int dummy_clks  = 6;  // Read wait cycles, bus released
    localparam int qe_gap_clks = 2;  // clk cycles with cs_n high after enter-quad

    // RAM commands
    localparam logic [cmd_w-1:0] cmd_quad_enable = 8'h35;  // Only ever sent in SPI mode on IO0
    localparam logic [cmd_w-1:0] cmd_quad_write  = 8'h38;
    localparam logic [cmd_w-1:0] cmd_quad_read   = 8'hEB;

    // Transaction phases
    typedef enum logic [3:0] {
        IDLE,
        QE_SEND,   // Enter-quad command, one bit per SPI clock
        QE_GAP,
        CMD,
        ADDR,
        DUMMY,
        DATA,
        DONE
    } qspi_phase_e;

    // Everything that goes out to the pads
    typedef struct packed {
        logic                sclk;
        logic                cs_n;
        logic [nibble_w-1:0] io_out;
        logic [nibble_w-1:0] io_oe;   // 1 = controller drives the line
    } qspi_pins_t;

endpackage

//--- hdl/mem_req_pkg.sv
package mem_req_pkg;

    // Host side sizes
    localparam int len_w            = 6;  // Data length field, in bits
    localparam int boot_mode_w      = 2;
    localparam int max_sample_delay = 3;  // Deepest read sample delay in clk

    // Read sample delay in clk, 0 to 3
    typedef logic [boot_mode_w-1:0] boot_mode_t;

    // One host access
    // Presented together with start, held until done or stop
    typedef struct packed {
        logic                          write;   // 1 = write, 0 = read
        logic [qspi_pkg::addr_w-1:0]   addr;
        logic [len_w-1:0]              len;     // Multiple of 4, from 4 to 32
        logic [qspi_pkg::data_w-1:0]   wdata;   // Sent MSB first
    } mem_req_t;

    // Completion back to the host
    typedef struct packed {
        logic                          done;    // One clk pulse
        logic [qspi_pkg::data_w-1:0]   rdata;   // Right justified to len
    } mem_rsp_t;

endpackage

//--- hdl/qspi_sequencer.sv
`timescale 1ns/100ps

module qspi_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  stop,
    input  mem_req_pkg::mem_req_t req,
    input  logic                  phase_last,
    output qspi_pkg::qspi_phase_e phase,
    output logic                  bit_tick,
    output logic                  done
);
    import qspi_pkg::*;

    qspi_phase_e phase_next;
    logic        quad_mode;     // RAM has taken the enter-quad command
    logic        half;          // SPI half-period toggle
    logic        spi_clocked;   // Phase runs the SPI clock

    assign spi_clocked = (phase == QE_SEND) || (phase == CMD) || (phase == ADDR) ||
                         (phase == DUMMY) || (phase == DATA);

    // Second half of each SPI clock, sclk falls at the end of it
    assign bit_tick = spi_clocked && half;

    assign done = (phase == DONE);

    always_comb begin
        phase_next = phase;
        case (phase)
            IDLE: begin
                if (start) begin
                    phase_next = quad_mode ? CMD : QE_SEND;
                end
            end
            QE_SEND: begin
                if (phase_last) begin
                    phase_next = QE_GAP;
                end
            end
            QE_GAP: begin
                if (phase_last) begin
                    phase_next = CMD;
                end
            end
            CMD: begin
                if (phase_last) begin
                    phase_next = ADDR;
                end
            end
            ADDR: begin
                if (phase_last) begin
                    phase_next = req.write ? DATA : DUMMY;   // Writes need no turnaround
                end
            end
            DUMMY: begin
                if (phase_last) begin
                    phase_next = DATA;
                end
            end
            DATA: begin
                if (phase_last) begin
                    phase_next = DONE;
                end
            end
            DONE:    phase_next = IDLE;
            default: phase_next = IDLE;
        endcase

        // Abort from anywhere, no done pulse
        if (stop) begin
            phase_next = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= IDLE;
            half      <= 1'b0;
            quad_mode <= 1'b0;
        end else begin
            phase <= phase_next;
            half  <= spi_clocked ? ~half : 1'b0;   // Every phase starts on a low half
            // Last bit is clocked in, the RAM switches when cs_n goes high
            if (phase == QE_SEND && phase_last) begin
                quad_mode <= 1'b1;
            end
        end
    end

    // DONE always falls back to IDLE, so done is a clean pulse
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done held high for more than one cycle");

endmodule

//--- hdl/qspi_shifter.sv
`timescale 1ns/100ps

module qspi_shifter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  qspi_pkg::qspi_phase_e         phase,
    input  logic                          bit_tick,
    input  logic                          sample,
    input  mem_req_pkg::mem_req_t         req,
    input  logic [qspi_pkg::nibble_w-1:0] io_in,
    output qspi_pkg::qspi_pins_t          pins,
    output logic [qspi_pkg::data_w-1:0]   rdata,
    output logic                          phase_last
);
    import qspi_pkg::*;

    logic [data_w-1:0] shift_out;
    logic [data_w-1:0] shift_in;
    logic [cmd_w-1:0]  cmd;
    logic [3:0]        cnt;         // SPI clocks, samples or gap cycles in this phase
    logic [3:0]        data_clks;   // Nibbles in the data phase
    logic              cnt_en;

    assign cmd       = req.write ? cmd_quad_write : cmd_quad_read;
    assign data_clks = 4'(req.len / nibble_w);

    // End of phase detect
    always_comb begin
        cnt_en     = bit_tick;
        phase_last = 1'b0;
        case (phase)
            QE_SEND: phase_last = bit_tick && (cnt == 4'(cmd_w - 1));
            QE_GAP: begin
                cnt_en     = 1'b1;   // Counted in clk, SPI clock is stopped
                phase_last = (cnt == 4'(qe_gap_clks - 1));
            end
            CMD:     phase_last = bit_tick && (cnt == 4'(cmd_w / nibble_w - 1));
            ADDR:    phase_last = bit_tick && (cnt == 4'(addr_w / nibble_w - 1));
            DUMMY:   phase_last = bit_tick && (cnt == 4'(dummy_clks - 1));
            DATA: begin
                // A read ends on its last delayed sample, not on the last clock
                if (!req.write) begin
                    cnt_en = sample;
                end
                phase_last = cnt_en && (cnt == data_clks - 4'd1);
            end
            default: phase_last = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (phase == IDLE || phase_last) begin
            cnt <= '0;
        end else if (cnt_en) begin
            cnt <= cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == IDLE || phase == QE_GAP) begin
            // Reloaded after QE_SEND, which shifts this register as well
            shift_out <= {cmd, req.addr};
            shift_in  <= '0;
        end else begin
            if (bit_tick) begin
                if (phase == ADDR && phase_last) begin
                    shift_out <= req.wdata;   // First data nibble ready for DATA
                end else begin
                    shift_out <= shift_out << nibble_w;
                end
            end
            if (phase == DATA && sample) begin
                shift_in <= {shift_in[data_w-nibble_w-1:0], io_in};
            end
        end

        // Valid in the DONE cycle and held until the next access ends
        if (phase == DATA && phase_last) begin
            rdata <= req.write ? '0 : {shift_in[data_w-nibble_w-1:0], io_in};
        end
    end

    // Pad drive
    always_comb begin
        pins.sclk   = bit_tick;   // High in the second half of each SPI clock
        pins.cs_n   = 1'b0;
        pins.io_out = '0;
        pins.io_oe  = '0;
        case (phase)
            QE_SEND: begin
                pins.io_oe  = '1;
                pins.io_out = {3'b111, cmd_quad_enable[~cnt[2:0]]};   // WP# and HOLD# kept high
            end
            CMD, ADDR: begin
                pins.io_oe  = '1;
                pins.io_out = shift_out[data_w-1 -: nibble_w];
            end
            DATA: begin
                if (req.write) begin
                    pins.io_oe  = '1;
                    pins.io_out = shift_out[data_w-1 -: nibble_w];
                end
            end
            DUMMY: pins.io_oe = '0;   // RAM turns the bus around
            default: pins.cs_n = 1'b1;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) pins.cs_n |-> (pins.io_oe == '0))
        else $error("pads driven while cs_n is high");

endmodule

//--- hdl/read_sample_delay.sv
`timescale 1ns/100ps

module read_sample_delay (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_req_pkg::boot_mode_t boot_mode,
    input  qspi_pkg::qspi_phase_e   phase,
    input  logic                    bit_tick,
    input  logic                    req_write,
    output logic                    sample
);
    import qspi_pkg::*;
    import mem_req_pkg::*;

    boot_mode_t                  mode_q;
    logic                        mode_valid;
    logic                        strobe;
    logic [max_sample_delay-1:0] dly;
    logic [max_sample_delay:0]   taps;

    // sclk is high in this cycle of a read data clock
    assign strobe = bit_tick && (phase == DATA) && !req_write;

    assign taps   = {dly, strobe};   // Tap n is n clk late
    assign sample = taps[mode_q];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q     <= '0;
            mode_valid <= 1'b0;
            dly        <= '0;
        end else begin
            if (!mode_valid) begin
                mode_q     <= boot_mode;   // Pins are free for other use afterwards
                mode_valid <= 1'b1;
            end
            dly <= {dly[max_sample_delay-2:0], strobe};
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mode_valid |=> $stable(mode_q))
        else $error("sample delay code changed after it was latched");

endmodule

//--- hdl/qspi_ram_ctrl.sv
`timescale 1ns/100ps

module qspi_ram_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mem_req_pkg::boot_mode_t       boot_mode,
    input  logic                          start,
    input  logic                          stop,
    input  mem_req_pkg::mem_req_t         req,
    output mem_req_pkg::mem_rsp_t         rsp,
    output qspi_pkg::qspi_pins_t          pins,
    input  logic [qspi_pkg::nibble_w-1:0] io_in
);
    import qspi_pkg::*;

    qspi_phase_e       phase;
    logic              bit_tick;
    logic              phase_last;
    logic              sample;
    logic              done;
    logic [data_w-1:0] rdata;

    qspi_sequencer qspi_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .stop       (stop),
        .req        (req),
        .phase_last (phase_last),
        .phase      (phase),
        .bit_tick   (bit_tick),
        .done       (done)
    );

    qspi_shifter qspi_shifter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .bit_tick   (bit_tick),
        .sample     (sample),
        .req        (req),
        .io_in      (io_in),
        .pins       (pins),
        .rdata      (rdata),
        .phase_last (phase_last)
    );

    read_sample_delay read_sample_delay_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_mode (boot_mode),
        .phase     (phase),
        .bit_tick  (bit_tick),
        .req_write (req.write),
        .sample    (sample)
    );

    assign rsp.done  = done;
    assign rsp.rdata = rdata;

endmodule

//--- sim/qspi_ram_model.sv
`timescale 1ns/100ps

module qspi_ram_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mem_req_pkg::boot_mode_t       resp_delay,   // Read data delay in clk
    input  qspi_pkg::qspi_pins_t          pins,
    output logic [qspi_pkg::nibble_w-1:0] io_in,
    output logic                          quad_mode
);
    import qspi_pkg::*;

    logic [7:0]  mem [0:255];
    logic        sclk;
    logic        cs_n;
    logic [5:0]  clk_cnt;   // SPI clocks since cs_n fell
    logic [7:0]  qe_byte;
    logic [7:0]  cmd_q;
    logic [23:0] addr_q;
    logic [3:0]  p0, p1, p2, p3;   // Read data pipe, one stage per clk of delay

    assign sclk = pins.sclk;
    assign cs_n = pins.cs_n;

    initial begin
        for (int k = 0; k < 256; k++) begin
            mem[k] = 8'(k) ^ 8'h3c;
        end
    end

    always @(posedge sclk or posedge cs_n or negedge rst_n) begin
        int         n;
        logic [7:0] a;
        if (!rst_n) begin
            quad_mode <= 1'b0;
            clk_cnt   <= '0;
            qe_byte   <= '0;
            p0        <= '0;
        end else if (cs_n) begin
            clk_cnt <= '0;   // End of a command
        end else begin
            clk_cnt <= clk_cnt + 6'd1;
            n = int'(clk_cnt);
            if (!quad_mode) begin
                // SPI mode, one bit per clock on IO0
                qe_byte <= {qe_byte[6:0], pins.io_out[0]};
                if (clk_cnt == 6'd7 && {qe_byte[6:0], pins.io_out[0]} == cmd_quad_enable) begin
                    quad_mode <= 1'b1;
                end
            end else if (clk_cnt < 6'd2) begin
                cmd_q <= {cmd_q[3:0], pins.io_out};
            end else if (clk_cnt < 6'd8) begin
                addr_q <= {addr_q[19:0], pins.io_out};
            end else if (cmd_q == cmd_quad_write) begin
                n = n - 8;
                a = addr_q[7:0] + 8'(n / 2);
                if ((n % 2) == 0) begin
                    mem[a][7:4] <= pins.io_out;
                end else begin
                    mem[a][3:0] <= pins.io_out;
                end
            end else if (cmd_q == cmd_quad_read && clk_cnt >= 6'd14) begin
                n = n - 14;   // After 6 dummy clocks
                a = addr_q[7:0] + 8'(n / 2);
                p0 <= ((n % 2) == 0) ? mem[a][7:4] : mem[a][3:0];
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p1 <= '0;
            p2 <= '0;
            p3 <= '0;
        end else begin
            p1 <= p0;
            p2 <= p1;
            p3 <= p2;
        end
    end

    always_comb begin
        case (resp_delay)
            2'd0:    io_in = p0;
            2'd1:    io_in = p1;
            2'd2:    io_in = p2;
            default: io_in = p3;
        endcase
    end

endmodule

//--- sim/tb_qspi_ram_ctrl.sv
`timescale 1ns/100ps

module tb_qspi_ram_ctrl;
    import qspi_pkg::*;
    import mem_req_pkg::*;

    localparam int clk_period   = 20;
    localparam int done_timeout = 400;   // clk cycles per access
    localparam int quiet_clks   = 100;   // Watch for a stray done after stop
    localparam int pat_words    = 7;

    logic          clk;
    logic          rst_n;
    boot_mode_t    boot_mode;
    logic          start;
    logic          stop;
    mem_req_t      req;
    mem_rsp_t      rsp;
    qspi_pins_t    pins;
    logic [3:0]    io_in;
    logic          model_quad;

    logic [31:0]   pat [0:255];
    integer        seed = 32'ha87e_34db;
    int            errors;
    int            test_errors;
    int            tests;
    logic [7:0]    qe_shift;   // First 8 bits seen on IO0 after reset
    int            qe_cnt;

    qspi_ram_ctrl qspi_ram_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_mode (boot_mode),
        .start     (start),
        .stop      (stop),
        .req       (req),
        .rsp       (rsp),
        .pins      (pins),
        .io_in     (io_in)
    );

    qspi_ram_model qspi_ram_model_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .resp_delay (boot_mode),
        .pins       (pins),
        .io_in      (io_in),
        .quad_mode  (model_quad)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic qspi_pins_t idle_pins();
        qspi_pins_t p;
        p = '0;
        p.cs_n = 1'b1;
        return p;
    endfunction

    task automatic check_pins(input qspi_pins_t got, input qspi_pins_t exp);
        if (got.sclk !== exp.sclk || got.cs_n !== exp.cs_n ||
            got.io_oe !== exp.io_oe) begin
            $display("Fail pins: sclk %h cs_n %h io_oe %h, expected sclk %h cs_n %h io_oe %h",
                     got.sclk, got.cs_n, got.io_oe, exp.sclk, exp.cs_n, exp.io_oe);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            $display("Fail rsp: done %h rdata %h, expected done %h rdata %h",
                     got.done, got.rdata, exp.done, exp.rdata);
            errors++;
            test_errors++;
        end
    endtask

    // Sample on the falling clk edge, where DUT outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            qe_cnt   <= 0;
            qe_shift <= '0;
        end else begin
            if (pins.cs_n) begin
                check_pins(pins, idle_pins());
            end
            if (!pins.cs_n && pins.sclk && qe_cnt < 8) begin
                qe_shift <= {qe_shift[6:0], pins.io_out[0]};
                qe_cnt   <= qe_cnt + 1;
            end
        end
    end

    task automatic apply_reset(input boot_mode_t mode);
        @(posedge clk);
        boot_mode <= mode;   // Latched by the DUT right after reset
        rst_n     <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic send_request(input mem_req_t r);
        @(posedge clk);
        req   <= r;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(output mem_rsp_t got);
        int cnt;
        cnt = 0;
        got = '0;
        while (!got.done && cnt < done_timeout) begin
            @(negedge clk);
            got = rsp;
            cnt++;
        end
        if (!got.done) begin
            $display("Timeout: no done pulse within %0d clock cycles", done_timeout);
            $display("tests failed");
            $finish;
        end
    endtask

    task automatic abort_access();
        int   n;
        int   cnt;
        logic seen;
        n = int'($unsigned($random(seed)) % 30) + 1;
        repeat (n) @(posedge clk);
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        @(negedge clk);
        check_pins(pins, idle_pins());
        cnt  = 0;
        seen = 1'b0;
        while (cnt < quiet_clks) begin
            @(negedge clk);
            if (rsp.done) begin
                seen = 1'b1;
            end
            cnt++;
        end
        if (seen) begin
            $display("Done pulse seen after stop at cycle %0d", n);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_quad_enable();
        if (qe_cnt != 8 || qe_shift != 8'h35 || !model_quad) begin
            $display("Enter-quad command not seen on IO0, or the RAM did not switch to quad mode");
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int n);
        $display("Test %0d: %s", n, (test_errors == 0) ? "ok" : "errors found");
    endtask

    initial begin
        int       i;
        int       cur_boot;
        int       cur_test;
        logic     fresh;
        mem_req_t r;
        mem_rsp_t got;
        mem_rsp_t exp;
        rst_n       = 1'b0;
        boot_mode   = '0;
        start       = 1'b0;
        stop        = 1'b0;
        req         = '0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        fresh       = 1'b0;
        $readmemh("sim/qspi_patterns.txt", pat);
        i        = 0;
        cur_boot = -1;
        cur_test = -1;
        while (pat[i] !== 32'hff && i < 248) begin
            if (int'(pat[i]) != cur_test) begin
                if (cur_test >= 0) begin
                    report_test(cur_test);
                end
                cur_test    = int'(pat[i]);
                test_errors = 0;
                tests++;
            end
            r.write   = (pat[i+1] == 32'd1);
            r.addr    = pat[i+3][23:0];
            r.len     = pat[i+4][5:0];
            r.wdata   = pat[i+5];
            exp.done  = 1'b1;
            exp.rdata = pat[i+6];
            // New sample delay needs a fresh boot
            if (int'(pat[i+2]) != cur_boot) begin
                cur_boot = int'(pat[i+2]);
                apply_reset(pat[i+2][1:0]);
                fresh = 1'b1;
            end
            if (pat[i+1] == 32'd2) begin
                send_request(r);
                abort_access();
            end
            send_request(r);
            wait_done(got);
            check_rsp(got, exp);
            if (fresh) begin
                check_quad_enable();
                fresh = 1'b0;
            end
            i += pat_words;
        end
        report_test(cur_test);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim/qspi_patterns.txt
// test op(0 read, 1 write, 2 read aborted then rerun) boot_mode addr len(bits) wdata rdata
// All values hex, the line with ff ends the list
01 1 0 000010 20 12345678 00000000
01 0 0 000010 20 00000000 12345678
02 1 0 000020 20 a5c30f96 00000000
02 0 0 000020 20 00000000 a5c30f96
03 1 0 000030 08 deadbeef 00000000
03 0 0 000030 08 00000000 000000de
04 0 1 000010 20 00000000 12345678
04 0 2 000020 20 00000000 a5c30f96
04 1 3 000040 10 beef1234 00000000
04 0 3 000040 10 00000000 0000beef
04 0 0 000030 08 00000000 000000de
05 2 0 000020 20 00000000 a5c30f96
ff

//--- compile.f
hdl/qspi_pkg.sv
hdl/mem_req_pkg.sv
hdl/qspi_sequencer.sv
hdl/qspi_shifter.sv
hdl/read_sample_delay.sv
hdl/qspi_ram_ctrl.sv
sim/qspi_ram_model.sv
sim/tb_qspi_ram_ctrl.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_qspi_ram_ctrl -f compile.f &&
    ./obj_dir/Vtb_qspi_ram_ctrl | tee /dev/stderr | grep -q "all tests passed" &&
    echo "Simulation PASSED" ||
    { echo "Simulation FAILED"; exit 1; }
